// File: core_exec_defines.svh
`ifndef CORE_EXEC_DEFINES_SVH
`define CORE_EXEC_DEFINES_SVH

// Operand and register width
`define CORE_DATA_W 8

// General registers A, X and Y
`define CORE_NUM_REGS 3

// Status flags C, Z, V and N, also the width of a flag mask
`define CORE_FLAG_W 4

`endif

// File: core_alu_pkg.sv
`include "core_exec_defines.svh"

package core_alu_pkg;

  typedef enum logic [3:0]
  {
    control_nop,
    control_adc,
    control_sbc,
    control_inc,
    control_dec,
    control_cmp,
    control_bit,
    control_and,
    control_or,
    control_xor,
    control_rol,
    control_asl,
    control_ror,
    control_lsr,
    control_txl,
    control_txr
  } control_type;

  // reg_none marks an instruction without register writeback
  typedef enum logic [1:0]
  {
    reg_a,
    reg_x,
    reg_y,
    reg_none
  } reg_sel_t;

  // Member order matches mask bits, C in bit 0 up to N in bit 3
  typedef struct packed
  {
    logic n;
    logic v;
    logic z;
    logic c;
  } flags_t;

  typedef struct packed
  {
    control_type             op;
    reg_sel_t                lhs_sel;
    reg_sel_t                rhs_sel;
    logic                    rhs_imm;
    logic [`CORE_DATA_W-1:0] imm;
    reg_sel_t                dst_sel;
    logic [`CORE_FLAG_W-1:0] mask_p;
  } instr_t;

  typedef struct packed
  {
    logic [`CORE_DATA_W-1:0] data;
    flags_t                  flags;
    reg_sel_t                dst;
  } result_t;

endpackage

// File: core_alu.sv
`timescale 1ns/1ps
`include "core_exec_defines.svh"

module core_alu
(
  input  core_alu_pkg::control_type op,
  input  logic [`CORE_FLAG_W-1:0]   mask_p,
  input  logic [`CORE_DATA_W-1:0]   lhs,
  input  logic [`CORE_DATA_W-1:0]   rhs,
  input  core_alu_pkg::flags_t      flags_in,
  output logic [`CORE_DATA_W-1:0]   result,
  output core_alu_pkg::flags_t      flags_out
);

  localparam int Msb = `CORE_DATA_W - 1;

  logic [`CORE_DATA_W-1:0] add_rhs;
  logic [`CORE_DATA_W:0]   sum;
  core_alu_pkg::flags_t    raw;

  // sbc adds the complement of rhs
  assign add_rhs = (op == core_alu_pkg::control_sbc) ? ~rhs : rhs;

  assign sum = {1'b0, lhs} + {1'b0, add_rhs} + {{`CORE_DATA_W{1'b0}}, flags_in.c};

  always_comb
  begin
    result = lhs;
    raw    = flags_in;

    case (op)
      core_alu_pkg::control_adc,
      core_alu_pkg::control_sbc:
      begin
        result = sum[Msb:0];
        raw.c  = sum[`CORE_DATA_W];
        // Signed overflow when like-signed operands give a differently signed sum
        raw.v  = (lhs[Msb] == add_rhs[Msb]) && (result[Msb] != lhs[Msb]);
      end
      core_alu_pkg::control_inc:
        result = lhs + 1'b1;
      core_alu_pkg::control_dec:
        result = lhs - 1'b1;
      core_alu_pkg::control_cmp:
        result = lhs - rhs;
      core_alu_pkg::control_bit,
      core_alu_pkg::control_and:
        result = lhs & rhs;
      core_alu_pkg::control_or:
        result = lhs | rhs;
      core_alu_pkg::control_xor:
        result = lhs ^ rhs;
      core_alu_pkg::control_rol:
        {raw.c, result} = {lhs, flags_in.c};
      core_alu_pkg::control_asl:
        {raw.c, result} = {lhs, 1'b0};
      core_alu_pkg::control_ror:
        {result, raw.c} = {flags_in.c, lhs};
      core_alu_pkg::control_lsr:
        {result, raw.c} = {1'b0, lhs};
      core_alu_pkg::control_txl:
        result = lhs;
      core_alu_pkg::control_txr:
        result = rhs;
      default:
      begin
        result = lhs;
      end
    endcase

    if (op != core_alu_pkg::control_nop)
    begin
      raw.z = (result == '0);
      raw.n = result[Msb];
    end

    // Flag overrides that do not come from the result
    case (op)
      core_alu_pkg::control_sbc:
        raw.c = ~raw.c;
      core_alu_pkg::control_cmp:
        raw.c = raw.z || (lhs > rhs);
      core_alu_pkg::control_bit:
      begin
        raw.v = rhs[Msb-1];
        raw.n = rhs[Msb];
      end
      default:
      begin
        raw.c = raw.c;
      end
    endcase
  end

  always_comb
  begin
    assert (!$isunknown(op))
    else $error("core_alu: undefined operation code %b", op);
  end

  // Unmasked flags keep their incoming value
  assign flags_out = core_alu_pkg::flags_t'((raw & mask_p) | (flags_in & ~mask_p));

endmodule

// File: core_regfile.sv
`timescale 1ns/1ps
`include "core_exec_defines.svh"

module core_regfile
(
  input  logic                    clk,
  input  logic                    arst_n,
  input  core_alu_pkg::reg_sel_t  rd_a_sel,
  input  core_alu_pkg::reg_sel_t  rd_b_sel,
  output logic [`CORE_DATA_W-1:0] rd_a_data,
  output logic [`CORE_DATA_W-1:0] rd_b_data,
  input  logic                    wr_en,
  input  core_alu_pkg::reg_sel_t  wr_sel,
  input  logic [`CORE_DATA_W-1:0] wr_data
);

  // A, X and Y in selector order
  logic [`CORE_DATA_W-1:0] regs [`CORE_NUM_REGS];

  always_ff @(posedge clk or negedge arst_n)
  begin
    if (!arst_n)
    begin
      for (int i = 0; i < `CORE_NUM_REGS; i++)
      begin
        regs[i] <= '0;
      end
    end
    else if (wr_en)
    begin
      regs[wr_sel] <= wr_data;
    end
  end

  // reg_none reads as zero
  assign rd_a_data = (rd_a_sel == core_alu_pkg::reg_none) ? '0 : regs[rd_a_sel];
  assign rd_b_data = (rd_b_sel == core_alu_pkg::reg_none) ? '0 : regs[rd_b_sel];

  a_wr_sel_valid: assert property (@(posedge clk) disable iff (!arst_n)
    wr_en |-> (wr_sel != core_alu_pkg::reg_none))
  else $error("core_regfile: write enabled with no destination register");

endmodule

// File: core_status.sv
`timescale 1ns/1ps

module core_status
(
  input  logic                 clk,
  input  logic                 arst_n,
  input  logic                 flags_we,
  input  core_alu_pkg::flags_t flags_d,
  output core_alu_pkg::flags_t flags_q
);

  // Processor status, C Z V N only
  always_ff @(posedge clk or negedge arst_n)
  begin
    if (!arst_n)
    begin
      flags_q <= '0;
    end
    else if (flags_we)
    begin
      flags_q <= flags_d;
    end
  end

endmodule

// File: core_exec_ctl.sv
`timescale 1ns/1ps
`include "core_exec_defines.svh"

module core_exec_ctl
(
  input  logic                      clk,
  input  logic                      arst_n,
  input  logic                      instr_valid,
  input  core_alu_pkg::instr_t      instr,
  output core_alu_pkg::reg_sel_t    rd_a_sel,
  output core_alu_pkg::reg_sel_t    rd_b_sel,
  input  logic [`CORE_DATA_W-1:0]   rd_a_data,
  input  logic [`CORE_DATA_W-1:0]   rd_b_data,
  output logic                      wr_en,
  output core_alu_pkg::reg_sel_t    wr_sel,
  output logic [`CORE_DATA_W-1:0]   wr_data,
  input  core_alu_pkg::flags_t      flags_q,
  output logic                      flags_we,
  output core_alu_pkg::flags_t      flags_d,
  output core_alu_pkg::control_type alu_op,
  output logic [`CORE_FLAG_W-1:0]   alu_mask_p,
  output logic [`CORE_DATA_W-1:0]   alu_lhs,
  output logic [`CORE_DATA_W-1:0]   alu_rhs,
  output core_alu_pkg::flags_t      alu_flags_in,
  input  logic [`CORE_DATA_W-1:0]   alu_result,
  input  core_alu_pkg::flags_t      alu_flags,
  output logic                      result_valid,
  output core_alu_pkg::result_t     result
);

  logic                    s1_valid;
  core_alu_pkg::instr_t    s1_instr;
  logic [`CORE_DATA_W-1:0] s1_lhs;
  logic [`CORE_DATA_W-1:0] s1_rhs;
  core_alu_pkg::flags_t    s1_flags;
  logic                    s1_writes;
  logic [`CORE_DATA_W-1:0] lhs_d;
  logic [`CORE_DATA_W-1:0] rhs_d;

  assign rd_a_sel = instr.lhs_sel;
  assign rd_b_sel = instr.rhs_sel;

  assign s1_writes = s1_valid && (s1_instr.dst_sel != core_alu_pkg::reg_none);

  // Stage 1 result bypasses the register file on a match
  always_comb
  begin
    lhs_d = rd_a_data;
    if (s1_writes && (s1_instr.dst_sel == instr.lhs_sel))
    begin
      lhs_d = alu_result;
    end

    if (instr.rhs_imm)
    begin
      rhs_d = instr.imm;
    end
    else if (s1_writes && (s1_instr.dst_sel == instr.rhs_sel))
    begin
      rhs_d = alu_result;
    end
    else
    begin
      rhs_d = rd_b_data;
    end
  end

  always_ff @(posedge clk or negedge arst_n)
  begin
    if (!arst_n)
    begin
      s1_valid     <= 1'b0;
      result_valid <= 1'b0;
    end
    else
    begin
      s1_valid     <= instr_valid;
      result_valid <= s1_valid;
    end
  end

  always_ff @(posedge clk)
  begin
    if (instr_valid)
    begin
      s1_instr <= instr;
      s1_lhs   <= lhs_d;
      s1_rhs   <= rhs_d;
      // Flags still in flight come straight from the ALU
      s1_flags <= s1_valid ? alu_flags : flags_q;
    end
    if (s1_valid)
    begin
      result <= '{data: alu_result, flags: alu_flags, dst: s1_instr.dst_sel};
    end
  end

  // Idle stage runs a nop
  assign alu_op       = s1_valid ? s1_instr.op : core_alu_pkg::control_nop;
  assign alu_mask_p   = s1_instr.mask_p;
  assign alu_lhs      = s1_lhs;
  assign alu_rhs      = s1_rhs;
  assign alu_flags_in = s1_flags;

  assign wr_en    = s1_writes;
  assign wr_sel   = s1_instr.dst_sel;
  assign wr_data  = alu_result;
  assign flags_we = s1_valid;
  assign flags_d  = alu_flags;

  a_latency: assert property (@(posedge clk) disable iff (!arst_n)
    instr_valid |-> ##2 result_valid)
  else $error("core_exec_ctl: accepted instruction did not retire after two cycles");

  // Register write and its completion pulse belong to one retirement
  a_wr_retire: assert property (@(posedge clk) disable iff (!arst_n)
    wr_en |=> result_valid)
  else $error("core_exec_ctl: register write without completion pulse");

endmodule

// File: core_exec_top.sv
`timescale 1ns/1ps
`include "core_exec_defines.svh"

module core_exec_top
(
  input  logic                  clk,
  input  logic                  arst_n,
  input  logic                  instr_valid,
  input  core_alu_pkg::instr_t  instr,
  output logic                  result_valid,
  output core_alu_pkg::result_t result
);

  core_alu_pkg::reg_sel_t    rd_a_sel;
  core_alu_pkg::reg_sel_t    rd_b_sel;
  logic [`CORE_DATA_W-1:0]   rd_a_data;
  logic [`CORE_DATA_W-1:0]   rd_b_data;
  logic                      wr_en;
  core_alu_pkg::reg_sel_t    wr_sel;
  logic [`CORE_DATA_W-1:0]   wr_data;
  core_alu_pkg::flags_t      flags_q;
  logic                      flags_we;
  core_alu_pkg::flags_t      flags_d;
  core_alu_pkg::control_type alu_op;
  logic [`CORE_FLAG_W-1:0]   alu_mask_p;
  logic [`CORE_DATA_W-1:0]   alu_lhs;
  logic [`CORE_DATA_W-1:0]   alu_rhs;
  core_alu_pkg::flags_t      alu_flags_in;
  logic [`CORE_DATA_W-1:0]   alu_result;
  core_alu_pkg::flags_t      alu_flags;

  core_exec_ctl u_ctl
  (
    .clk          (clk),
    .arst_n       (arst_n),
    .instr_valid  (instr_valid),
    .instr        (instr),
    .rd_a_sel     (rd_a_sel),
    .rd_b_sel     (rd_b_sel),
    .rd_a_data    (rd_a_data),
    .rd_b_data    (rd_b_data),
    .wr_en        (wr_en),
    .wr_sel       (wr_sel),
    .wr_data      (wr_data),
    .flags_q      (flags_q),
    .flags_we     (flags_we),
    .flags_d      (flags_d),
    .alu_op       (alu_op),
    .alu_mask_p   (alu_mask_p),
    .alu_lhs      (alu_lhs),
    .alu_rhs      (alu_rhs),
    .alu_flags_in (alu_flags_in),
    .alu_result   (alu_result),
    .alu_flags    (alu_flags),
    .result_valid (result_valid),
    .result       (result)
  );

  core_alu u_alu
  (
    .op        (alu_op),
    .mask_p    (alu_mask_p),
    .lhs       (alu_lhs),
    .rhs       (alu_rhs),
    .flags_in  (alu_flags_in),
    .result    (alu_result),
    .flags_out (alu_flags)
  );

  core_regfile u_regfile
  (
    .clk       (clk),
    .arst_n    (arst_n),
    .rd_a_sel  (rd_a_sel),
    .rd_b_sel  (rd_b_sel),
    .rd_a_data (rd_a_data),
    .rd_b_data (rd_b_data),
    .wr_en     (wr_en),
    .wr_sel    (wr_sel),
    .wr_data   (wr_data)
  );

  core_status u_status
  (
    .clk      (clk),
    .arst_n   (arst_n),
    .flags_we (flags_we),
    .flags_d  (flags_d),
    .flags_q  (flags_q)
  );

endmodule

// File: tb_core_exec.sv
`timescale 1ns/1ps
`include "core_exec_defines.svh"

module tb_core_exec;

  localparam int Msb = `CORE_DATA_W - 1;

  logic                  clk;
  logic                  arst_n;
  logic                  instr_valid;
  core_alu_pkg::instr_t  instr;
  logic                  result_valid;
  core_alu_pkg::result_t result;

  int seed   = 32'h203b_193a;
  int errors = 0;
  int cycle  = 0;

  // Model state, entry 3 stands for reg_none and is never written
  logic [`CORE_DATA_W-1:0] model_regs [4];
  core_alu_pkg::flags_t    model_flags;

  core_alu_pkg::result_t exp_q [$];
  int                    due_q [$];

  core_alu_pkg::control_type arith_ops [5] = '{core_alu_pkg::control_adc,
    core_alu_pkg::control_sbc, core_alu_pkg::control_inc, core_alu_pkg::control_dec,
    core_alu_pkg::control_cmp};
  core_alu_pkg::control_type logic_ops [8] = '{core_alu_pkg::control_and,
    core_alu_pkg::control_or, core_alu_pkg::control_xor, core_alu_pkg::control_bit,
    core_alu_pkg::control_rol, core_alu_pkg::control_asl, core_alu_pkg::control_ror,
    core_alu_pkg::control_lsr};

  core_exec_top DUT
  (
    .clk          (clk),
    .arst_n       (arst_n),
    .instr_valid  (instr_valid),
    .instr        (instr),
    .result_valid (result_valid),
    .result       (result)
  );

  always #20 clk = ~clk;

  always @(posedge clk) cycle = cycle + 1;

  function automatic int unsigned rnd(input int unsigned n);
    rnd = $unsigned($random(seed)) % n;
  endfunction

  function automatic core_alu_pkg::reg_sel_t pick_reg(input int unsigned n);
    pick_reg = core_alu_pkg::reg_sel_t'(2'(rnd(n)));
  endfunction

  function automatic void ref_alu
  (
    input  core_alu_pkg::control_type op,
    input  logic [`CORE_FLAG_W-1:0]   mask_p,
    input  logic [`CORE_DATA_W-1:0]   a,
    input  logic [`CORE_DATA_W-1:0]   b,
    input  core_alu_pkg::flags_t      fin,
    output logic [`CORE_DATA_W-1:0]   res,
    output core_alu_pkg::flags_t      fout
  );
    logic [`CORE_DATA_W:0]   wide;
    logic [`CORE_DATA_W-1:0] nb;
    core_alu_pkg::flags_t    f;
    f   = fin;
    res = a;
    // Subtraction is addition of the complement
    nb  = (op == core_alu_pkg::control_sbc) ? ~b : b;
    case (op)
      core_alu_pkg::control_adc,
      core_alu_pkg::control_sbc:
      begin
        wide = {1'b0, a} + {1'b0, nb} + {{`CORE_DATA_W{1'b0}}, fin.c};
        res  = wide[Msb:0];
        f.c  = (op == core_alu_pkg::control_sbc) ? ~wide[`CORE_DATA_W] : wide[`CORE_DATA_W];
        f.v  = (a[Msb] == nb[Msb]) && (res[Msb] != a[Msb]);
      end
      core_alu_pkg::control_inc: res = a + 1'b1;
      core_alu_pkg::control_dec: res = a - 1'b1;
      core_alu_pkg::control_cmp: res = a - b;
      core_alu_pkg::control_bit,
      core_alu_pkg::control_and: res = a & b;
      core_alu_pkg::control_or:  res = a | b;
      core_alu_pkg::control_xor: res = a ^ b;
      core_alu_pkg::control_rol:
      begin
        res = {a[Msb-1:0], fin.c};
        f.c = a[Msb];
      end
      core_alu_pkg::control_asl:
      begin
        res = {a[Msb-1:0], 1'b0};
        f.c = a[Msb];
      end
      core_alu_pkg::control_ror:
      begin
        res = {fin.c, a[Msb:1]};
        f.c = a[0];
      end
      core_alu_pkg::control_lsr:
      begin
        res = {1'b0, a[Msb:1]};
        f.c = a[0];
      end
      core_alu_pkg::control_txr: res = b;
      default: res = a;
    endcase
    if (op != core_alu_pkg::control_nop)
    begin
      f.z = (res == '0);
      f.n = res[Msb];
    end
    if (op == core_alu_pkg::control_cmp)
      f.c = f.z || (a > b);
    if (op == core_alu_pkg::control_bit)
    begin
      f.v = b[Msb-1];
      f.n = b[Msb];
    end
    for (int i = 0; i < `CORE_FLAG_W; i++)
      fout[i] = mask_p[i] ? f[i] : fin[i];
  endfunction

  task automatic send
  (
    input core_alu_pkg::control_type op,
    input core_alu_pkg::reg_sel_t    lhs_sel,
    input core_alu_pkg::reg_sel_t    rhs_sel,
    input logic                      rhs_imm,
    input logic [`CORE_DATA_W-1:0]   imm,
    input core_alu_pkg::reg_sel_t    dst_sel,
    input logic [`CORE_FLAG_W-1:0]   mask_p
  );
    logic [`CORE_DATA_W-1:0] rhs;
    logic [`CORE_DATA_W-1:0] res;
    core_alu_pkg::flags_t    fl;
    core_alu_pkg::result_t   expd;
    @(posedge clk);
    #2;
    instr.op      = op;
    instr.lhs_sel = lhs_sel;
    instr.rhs_sel = rhs_sel;
    instr.rhs_imm = rhs_imm;
    instr.imm     = imm;
    instr.dst_sel = dst_sel;
    instr.mask_p  = mask_p;
    instr_valid   = 1'b1;
    rhs = rhs_imm ? imm : model_regs[rhs_sel];
    ref_alu(op, mask_p, model_regs[lhs_sel], rhs, model_flags, res, fl);
    if (dst_sel != core_alu_pkg::reg_none)
      model_regs[dst_sel] = res;
    model_flags = fl;
    expd.data   = res;
    expd.flags  = fl;
    expd.dst    = dst_sel;
    exp_q.push_back(expd);
    // Accepted at the next edge, pulse seen in the cycle after that
    due_q.push_back(cycle + 2);
  endtask

  task automatic send_random(input core_alu_pkg::control_type op,
                             input logic [`CORE_FLAG_W-1:0] mask_p, input int unsigned dst_n);
    send(op, pick_reg(3), pick_reg(3), 1'(rnd(2)), 8'(rnd(256)), pick_reg(dst_n), mask_p);
  endtask

  task automatic go_idle;
    @(posedge clk);
    #2;
    instr_valid = 1'b0;
  endtask

  always @(negedge clk)
  begin
    if (arst_n && result_valid)
    begin
      if (exp_q.size() == 0)
      begin
        $display("Completion pulse at %0t with no instruction outstanding", $time);
        errors++;
      end
      else
      begin
        if (due_q[0] != cycle)
        begin
          $display("FAIL %0t result_valid cycle expected %0d got %0d", $time, due_q[0], cycle);
          errors++;
        end
        if (result.data != exp_q[0].data)
        begin
          $display("FAIL %0t result.data expected %h got %h", $time, exp_q[0].data, result.data);
          errors++;
        end
        if (result.flags != exp_q[0].flags)
        begin
          $display("FAIL %0t result.flags expected %b got %b", $time, exp_q[0].flags,
                   result.flags);
          errors++;
        end
        if (result.dst != exp_q[0].dst)
        begin
          $display("FAIL %0t result.dst expected %0d got %0d", $time, exp_q[0].dst, result.dst);
          errors++;
        end
        void'(exp_q.pop_front());
        void'(due_q.pop_front());
      end
    end
    else if (arst_n && (exp_q.size() != 0) && (due_q[0] <= cycle))
    begin
      $display("Result due in cycle %0d never pulsed (time %0t)", due_q[0], $time);
      errors++;
      void'(exp_q.pop_front());
      void'(due_q.pop_front());
    end
  end

  initial
  begin
    int wait_cnt;
    clk         = 1'b0;
    arst_n      = 1'b0;
    instr_valid = 1'b0;
    instr       = '0;
    model_flags = '0;
    for (int r = 0; r < 4; r++)
      model_regs[r] = '0;
    repeat (4) @(posedge clk);
    #2;
    arst_n = 1'b1;
    if (result_valid !== 1'b0)
    begin
      $display("FAIL %0t result_valid expected 0 got %b", $time, result_valid);
      errors++;
    end

    // Cleared registers read back through txl
    for (int r = 0; r < 3; r++)
      send(core_alu_pkg::control_txl, core_alu_pkg::reg_sel_t'(2'(r)), core_alu_pkg::reg_a,
           1'b0, 8'h00, core_alu_pkg::reg_sel_t'(2'(r)), 4'hf);
    for (int r = 0; r < 3; r++)
      send(core_alu_pkg::control_txr, core_alu_pkg::reg_a, core_alu_pkg::reg_a, 1'b1,
           8'(rnd(256)), core_alu_pkg::reg_sel_t'(2'(r)), 4'hf);
    for (int i = 0; i < 24; i++)
      send_random(arith_ops[rnd(5)], 4'hf, 3);
    for (int i = 0; i < 32; i++)
      send_random(logic_ops[rnd(8)], 4'hf, 3);

    // Random masks, any op, idle gaps
    for (int i = 0; i < 40; i++)
    begin
      if (rnd(4) == 0)
        go_idle();
      send_random(core_alu_pkg::control_type'(4'(rnd(16))), 4'(rnd(16)), 4);
    end

    // Dependent chain on A and C
    send(core_alu_pkg::control_txr, core_alu_pkg::reg_a, core_alu_pkg::reg_a, 1'b1, 8'h7f,
         core_alu_pkg::reg_a, 4'hf);
    send(core_alu_pkg::control_adc, core_alu_pkg::reg_a, core_alu_pkg::reg_a, 1'b1, 8'h01,
         core_alu_pkg::reg_a, 4'hf);
    send(core_alu_pkg::control_adc, core_alu_pkg::reg_a, core_alu_pkg::reg_a, 1'b0, 8'h00,
         core_alu_pkg::reg_a, 4'hf);
    send(core_alu_pkg::control_rol, core_alu_pkg::reg_a, core_alu_pkg::reg_a, 1'b0, 8'h00,
         core_alu_pkg::reg_a, 4'hf);
    send(core_alu_pkg::control_cmp, core_alu_pkg::reg_a, core_alu_pkg::reg_x, 1'b0, 8'h00,
         core_alu_pkg::reg_none, 4'hf);
    send(core_alu_pkg::control_sbc, core_alu_pkg::reg_x, core_alu_pkg::reg_a, 1'b0, 8'h00,
         core_alu_pkg::reg_x, 4'hf);
    send(core_alu_pkg::control_nop, core_alu_pkg::reg_a, core_alu_pkg::reg_a, 1'b0, 8'h00,
         core_alu_pkg::reg_none, 4'hf);
    send(core_alu_pkg::control_ror, core_alu_pkg::reg_x, core_alu_pkg::reg_x, 1'b0, 8'h00,
         core_alu_pkg::reg_x, 4'hf);
    go_idle();

    wait_cnt = 0;
    while ((exp_q.size() != 0) && (wait_cnt < 20))
    begin
      @(posedge clk);
      wait_cnt++;
    end
    if (exp_q.size() != 0)
    begin
      $display("Timed out with %0d results still outstanding", exp_q.size());
      errors++;
    end
    // Quiet cycles, no pulse expected
    repeat (3) @(posedge clk);

    $display("Error count: %0d", errors);
    if (errors == 0)
      $display("NO ERRORS");
    else
      $display("ERRORS FOUND");
    $finish;
  end

endmodule

// File: core_exec.f
+incdir+.
core_alu_pkg.sv
core_alu.sv
core_regfile.sv
core_status.sv
core_exec_ctl.sv
core_exec_top.sv
tb_core_exec.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Build and run the execute unit testbench with Verilator
set -u
cd "$(dirname "$0")"

LOG=sim.log

verilator --binary --timing --assert --top-module tb_core_exec -f core_exec.f -o sim_core_exec
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/sim_core_exec > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -qx "NO ERRORS" "$LOG"; then
  exit 0
fi
echo "Pass message not found in $LOG"
exit 1
